/* idStage.f */
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/aluDecoder.sv
rtl/memDecoder.sv
rtl/writebackDecoder.sv
rtl/branchUnit.sv
rtl/exceptionDetect.sv
rtl/pipeReg.sv
rtl/idStage.sv
verif/idStage_tb.sv

/* verif/idStage_tb.sv */
module idStage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;
	import ctrlPkg::*;

	localparam int period = 100;
	localparam int numInstr = 151; // Every driven cycle, resets and settling included
	localparam logic [31:0] nopWord = 32'h0000_0000;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        instrValid;
	logic        stall;
	logic        flush;
	logic        fetchExc;
	excCode_t    fetchExcCode;
	logic        cmpEq;
	cmpSign_t    cmpSign;
	npcOp_t      npcOp;
	logic        nullifySlot;
	logic        exValid;
	aluOp_t      exAluOp;
	logic        exShiftByShamt;
	extOp_t      exExtOp;
	logic        exRegWrite;
	dstSel_t     exDstSel;
	wbSel_t      exWbSel;
	logic        exMemRead;
	logic        exMemWrite;
	memSize_t    exMemSize;
	logic        exIsBranch;
	logic        exException;
	excCode_t    exExcCode;
	logic        exInDelaySlot;

	int failCount = 0;
	int testStart = 0;
	int testCount = 0;
	int failedTests = 0;

	idStage UUT (.*);

	always #(period / 2) clk = ~clk;

	// --------------------
	// Reference decode rules
	function automatic logic [3:0] refFlow(logic [31:0] w, logic eq, cmpSign_t s);
		logic [5:0] op;
		logic [4:0] rt;
		logic       br;
		logic       cond;
		logic       likely;
		npcOp_t     npc;
		op = w[31:26];
		rt = w[20:16];
		br = 1'b1;
		cond = 1'b0;
		npc = npcSeq;
		case (op)
			opBeq, opBeql:   cond = eq;
			opBne, opBnel:   cond = !eq;
			opBlez, opBlezl: cond = (s != cmpPos); // Zero or negative
			opBgtz, opBgtzl: cond = (s == cmpPos);
			opRegimm: begin
				if (rt inside {rtBltz, rtBltzl, rtBltzal})
					cond = (s == cmpNeg);
				else if (rt inside {rtBgez, rtBgezl, rtBgezal})
					cond = (s != cmpNeg);
				else
					br = 1'b0;
			end
			opJ, opJal: npc = npcJump;
			opSpecial: begin
				if (w[5:0] == fnJr || w[5:0] == fnJalr)
					npc = npcReg;
				else
					br = 1'b0;
			end
			default: br = 1'b0;
		endcase
		likely = (op inside {opBeql, opBnel, opBlezl, opBgtzl})
			|| (op == opRegimm && rt inside {rtBltzl, rtBgezl});
		if (cond)
			npc = npcBranch;
		return {br, npc, likely && !cond}; // isBranch, npcOp, nullifySlot
	endfunction

	function automatic ctrlWord_t refCtrl(logic [31:0] w);
		ctrlWord_t  c;
		logic [5:0] op;
		logic [5:0] fn;
		logic [3:0] flow;
		logic       isLoad;
		logic       isStore;
		op = w[31:26];
		fn = w[5:0];
		flow = refFlow(w, 1'b0, cmpZero);
		isLoad = op inside {opLb, opLh, opLw, opLbu, opLhu};
		isStore = op inside {opSb, opSh, opSw};
		c = '0;
		c.aluOp = aluNone;
		c.memSize = memWord;
		c.isBranch = flow[3];
		if (op == opSpecial) begin
			c.dstSel = dstRd;
			c.wbSel = (fn == fnJalr) ? wbLink : wbAlu;
			c.shiftByShamt = fn inside {fnSll, fnSrl, fnSra};
			case (fn)
				fnAdd:         c.aluOp = aluAdd;
				fnAddu:        c.aluOp = aluAddu;
				fnSub:         c.aluOp = aluSub;
				fnSubu:        c.aluOp = aluSubu;
				fnAnd:         c.aluOp = aluAnd;
				fnOr:          c.aluOp = aluOr;
				fnXor:         c.aluOp = aluXor;
				fnNor:         c.aluOp = aluNor;
				fnSlt:         c.aluOp = aluSlt;
				fnSltu:        c.aluOp = aluSltu;
				fnSll, fnSllv: c.aluOp = aluSll;
				fnSrl, fnSrlv: c.aluOp = aluSrl;
				fnSra, fnSrav: c.aluOp = aluSra;
				default:       c.aluOp = aluNone;
			endcase
			c.regWrite = (c.aluOp != aluNone) || (fn == fnJalr); // ALU ops and jalr
		end
		case (op)
			opAddi:  c.aluOp = aluAdd;
			opAddiu: c.aluOp = aluAddu;
			opSlti:  c.aluOp = aluSlt;
			opSltiu: c.aluOp = aluSltu;
			opAndi:  c.aluOp = aluAnd;
			opOri:   c.aluOp = aluOr;
			opXori:  c.aluOp = aluXor;
			default: ;
		endcase
		if (op inside {opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori})
			c.regWrite = 1'b1;
		if (op inside {opAddi, opAddiu, opSlti, opSltiu} || isLoad || isStore)
			c.extOp = extSign;
		if (op == opLui) begin
			c.extOp = extLui;
			c.regWrite = 1'b1;
			c.wbSel = wbImm;
		end
		if (isLoad || isStore)
			c.aluOp = aluAdd; // Base plus offset
		if (isLoad) begin
			c.memRead = 1'b1;
			c.regWrite = 1'b1;
			c.wbSel = wbMem;
		end
		c.memWrite = isStore;
		if (op inside {opLb, opSb})
			c.memSize = memByte;
		else if (op == opLbu)
			c.memSize = memByteU;
		else if (op inside {opLh, opSh})
			c.memSize = memHalf;
		else if (op == opLhu)
			c.memSize = memHalfU;
		if (op == opJal || (op == opRegimm && w[20:16] inside {rtBltzal, rtBgezal})) begin
			c.regWrite = 1'b1;
			c.dstSel = dstLink;
			c.wbSel = wbLink;
		end
		return c;
	endfunction

	function automatic excInfo_t refExc(logic [31:0] w, logic fExc, excCode_t fCode,
		logic hold, logic prev);
		ctrlWord_t c;
		excInfo_t  e;
		logic      brk;
		logic      sys;
		c = refCtrl(w);
		brk = (w[31:26] == opSpecial) && (w[5:0] == fnBreak);
		sys = (w[31:26] == opSpecial) && (w[5:0] == fnSyscall);
		e.inDelaySlot = prev;
		e.exception = 1'b1;
		if (fExc)
			e.excCode = fCode;
		else if (!(c.regWrite || c.memWrite || c.isBranch || brk || sys) && !hold)
			e.excCode = 5'h0a;
		else if (brk)
			e.excCode = 5'h09;
		else if (sys)
			e.excCode = 5'h08;
		else begin
			e.exception = 1'b0;
			e.excCode = 5'h00;
		end
		return e;
	endfunction

	// --------------------
	// Expected execute stage
	logic      expValid;
	logic      expHold;
	ctrlWord_t expCtrl;
	excInfo_t  expExc;
	logic [3:0] expFlow;

	assign expFlow = refFlow(instr, cmpEq, cmpSign);

	always @(posedge clk) begin
		if (!rst || flush) begin
			expValid <= 1'b0;
			expCtrl <= '0;
			expExc <= '0;
		end
		else if (!stall) begin
			expValid <= instrValid;
			expCtrl <= refCtrl(instr);
			expExc <= refExc(instr, fetchExc, fetchExcCode, expHold, expCtrl.isBranch);
		end
		expHold <= !rst; // Reserved instruction stays quiet one cycle past reset
	end

	task automatic mismatch(input string name, input logic [31:0] expVal, input logic [31:0] gotVal);
		failCount++;
		$display("CHECK FAILED %s expected %h got %h at %0t", name, expVal, gotVal, $time);
	endtask

	task automatic complain(input string what);
		failCount++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// --------------------
	// Checks
	assert property (@(posedge clk) disable iff (!rst) npcOp == expFlow[2:1])
		else mismatch("npcOp", $sampled(expFlow[2:1]), $sampled(npcOp));
	assert property (@(posedge clk) disable iff (!rst) nullifySlot == expFlow[0])
		else mismatch("nullifySlot", $sampled(expFlow[0]), $sampled(nullifySlot));
	assert property (@(posedge clk) disable iff (!rst) exValid == expValid)
		else mismatch("exValid", $sampled(expValid), $sampled(exValid));
	assert property (@(posedge clk) disable iff (!rst) exAluOp == expCtrl.aluOp)
		else mismatch("exAluOp", $sampled(expCtrl.aluOp), $sampled(exAluOp));
	assert property (@(posedge clk) disable iff (!rst) exShiftByShamt == expCtrl.shiftByShamt)
		else mismatch("exShiftByShamt", $sampled(expCtrl.shiftByShamt), $sampled(exShiftByShamt));
	assert property (@(posedge clk) disable iff (!rst) exExtOp == expCtrl.extOp)
		else mismatch("exExtOp", $sampled(expCtrl.extOp), $sampled(exExtOp));
	assert property (@(posedge clk) disable iff (!rst) exRegWrite == expCtrl.regWrite)
		else mismatch("exRegWrite", $sampled(expCtrl.regWrite), $sampled(exRegWrite));
	assert property (@(posedge clk) disable iff (!rst) exDstSel == expCtrl.dstSel)
		else mismatch("exDstSel", $sampled(expCtrl.dstSel), $sampled(exDstSel));
	assert property (@(posedge clk) disable iff (!rst) exWbSel == expCtrl.wbSel)
		else mismatch("exWbSel", $sampled(expCtrl.wbSel), $sampled(exWbSel));
	assert property (@(posedge clk) disable iff (!rst) exMemRead == expCtrl.memRead)
		else mismatch("exMemRead", $sampled(expCtrl.memRead), $sampled(exMemRead));
	assert property (@(posedge clk) disable iff (!rst) exMemWrite == expCtrl.memWrite)
		else mismatch("exMemWrite", $sampled(expCtrl.memWrite), $sampled(exMemWrite));
	assert property (@(posedge clk) disable iff (!rst) exMemSize == expCtrl.memSize)
		else mismatch("exMemSize", $sampled(expCtrl.memSize), $sampled(exMemSize));
	assert property (@(posedge clk) disable iff (!rst) exIsBranch == expCtrl.isBranch)
		else mismatch("exIsBranch", $sampled(expCtrl.isBranch), $sampled(exIsBranch));
	assert property (@(posedge clk) disable iff (!rst) exException == expExc.exception)
		else mismatch("exException", $sampled(expExc.exception), $sampled(exException));
	assert property (@(posedge clk) disable iff (!rst) exExcCode == expExc.excCode)
		else mismatch("exExcCode", $sampled(expExc.excCode), $sampled(exExcCode));
	assert property (@(posedge clk) disable iff (!rst) exInDelaySlot == expExc.inDelaySlot)
		else mismatch("exInDelaySlot", $sampled(expExc.inDelaySlot), $sampled(exInDelaySlot));

	// Pipeline control, independent of the decode rules
	assert property (@(posedge clk) disable iff (!rst) (stall && !flush)
		|=> $stable({exValid, exAluOp, exRegWrite, exMemSize, exException, exExcCode}))
		else complain("execute outputs changed while stalled");
	assert property (@(posedge clk) disable iff (!rst) flush |=> !exValid && !exException)
		else complain("execute stage still valid after flush");
	assert property (@(posedge clk) disable iff (!rst) $rose(rst) |-> !exValid && !exException)
		else complain("execute stage not cleared by reset");
	assert property (@(posedge clk) disable iff (!rst)
		(exIsBranch && !stall && !flush) |=> exInDelaySlot)
		else complain("instruction after a branch not marked as delay slot");

	// --------------------
	// Stimulus helpers
	function automatic logic [31:0] rType(logic [5:0] fn);
		return {6'b000000, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom), fn};
	endfunction

	function automatic logic [31:0] iType(logic [5:0] op);
		return {op, 5'($urandom), 5'($urandom), 16'($urandom)};
	endfunction

	function automatic logic [31:0] regimm(logic [4:0] rt);
		return {opRegimm, 5'($urandom), rt, 16'($urandom)};
	endfunction

	task automatic issue(input logic [31:0] w);
		instr = w;
		@(posedge clk);
		#10;
	endtask

	task automatic applyReset();
		rst = 1'b0;
		repeat (3) @(posedge clk);
		#10;
		rst = 1'b1;
	endtask

	task automatic finishTest(input string name);
		issue(nopWord); // Let the last instruction reach the checks
		issue(nopWord);
		testCount++;
		if (failCount == testStart) begin
			$display("test %s finished, all checks held", name);
		end
		else begin
			failedTests++;
			$display("test %s finished, %0d checks failed", name, failCount - testStart);
		end
		testStart = failCount;
	endtask

	// --------------------
	// Tests
	initial begin
		logic [5:0] aluFns[16] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
			fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};
		logic [5:0] immOps[16] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori,
			opLui, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
		logic [5:0] brOps[8] = '{opBeq, opBne, opBlez, opBgtz, opBeql, opBnel, opBlezl, opBgtzl};
		logic [4:0] brRts[4] = '{rtBltz, rtBgez, rtBltzl, rtBgezl};
		void'($urandom(70));
		instr = nopWord;
		instrValid = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		fetchExc = 1'b0;
		fetchExcCode = 5'h00;
		cmpEq = 1'b0;
		cmpSign = cmpZero;
		applyReset();

		foreach (aluFns[i])
			issue(rType(aluFns[i]));
		foreach (immOps[i])
			issue(iType(immOps[i]));
		finishTest("alu decode");

		foreach (immOps[i])
			if (i >= 8)
				issue(iType(immOps[i])); // Loads and stores
		issue({opJal, 26'($urandom)});
		issue(rType(fnJalr));
		issue(regimm(rtBltzal));
		issue(regimm(rtBgezal));
		finishTest("memory and writeback");

		for (int e = 0; e < 2; e++) begin
			for (int s = 0; s < 3; s++) begin
				cmpEq = e[0];
				cmpSign = cmpSign_t'(s[1:0]); // Zero, positive, negative
				foreach (brOps[i])
					issue(iType(brOps[i]));
				foreach (brRts[i])
					issue(regimm(brRts[i]));
			end
		end
		issue({opJ, 26'($urandom)});
		issue(rType(fnJr));
		finishTest("branch decision");

		issue(iType(6'h10)); // Coprocessor 0 is not kept
		issue(iType(6'h1c));
		issue(rType(6'h18)); // mult went away with the HI/LO unit
		issue(rType(fnBreak));
		issue(rType(fnSyscall));
		fetchExc = 1'b1;
		fetchExcCode = 5'h04;
		issue(rType(fnBreak));
		fetchExcCode = 5'h06;
		issue(nopWord);
		fetchExc = 1'b0;
		flush = 1'b1;
		issue(iType(6'h3f));
		flush = 1'b0;
		finishTest("exceptions");

		issue(rType(fnAdd));
		stall = 1'b1;
		issue(iType(opLw));
		issue(iType(opSw));
		stall = 1'b0;
		issue(iType(opOri));
		stall = 1'b1;
		flush = 1'b1;
		issue(iType(opAddi));
		stall = 1'b0;
		flush = 1'b0;
		instrValid = 1'b0;
		issue(nopWord);
		instrValid = 1'b1;
		issue(iType(opBeq));
		issue(rType(fnAdd)); // Sits in the delay slot
		instr = {6'h3f, 26'($urandom)};
		applyReset();
		issue(instr); // Reserved opcode right after reset
		finishTest("pipeline control");

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			testCount, failedTests, failCount);
		if (failCount == 0) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#((numInstr + 20) * period);
		$display("Watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* rtl/idStage.sv */
module idStage (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [isaPkg::instrWidth-1:0] instr,
	input  logic                          instrValid,
	input  logic                          stall,
	input  logic                          flush,
	input  logic                          fetchExc,
	input  ctrlPkg::excCode_t             fetchExcCode,
	input  logic                          cmpEq,
	input  ctrlPkg::cmpSign_t             cmpSign,
	output ctrlPkg::npcOp_t               npcOp,
	output logic                          nullifySlot,
	output logic                          exValid,
	output ctrlPkg::aluOp_t               exAluOp,
	output logic                          exShiftByShamt,
	output ctrlPkg::extOp_t               exExtOp,
	output logic                          exRegWrite,
	output ctrlPkg::dstSel_t              exDstSel,
	output ctrlPkg::wbSel_t               exWbSel,
	output logic                          exMemRead,
	output logic                          exMemWrite,
	output ctrlPkg::memSize_t             exMemSize,
	output logic                          exIsBranch,
	output logic                          exException,
	output ctrlPkg::excCode_t             exExcCode,
	output logic                          exInDelaySlot
);
	import ctrlPkg::*;

	aluOp_t    aluOp;
	logic      shiftByShamt;
	extOp_t    extOp;
	logic      regWrite;
	dstSel_t   dstSel;
	wbSel_t    wbSel;
	logic      memRead;
	logic      memWrite;
	memSize_t  memSize;
	logic      isBranch;
	logic      exception;
	excCode_t  excCode;
	logic      inDelaySlot;
	ctrlWord_t idCtrl;
	ctrlWord_t exCtrl;
	excInfo_t  idExc;
	excInfo_t  exExc;

	// --------------------
	// Decoders
	aluDecoder aluDec (.instr(instr), .aluOp(aluOp), .shiftByShamt(shiftByShamt), .extOp(extOp));

	memDecoder memDec (.instr(instr), .memRead(memRead), .memWrite(memWrite), .memSize(memSize));

	writebackDecoder wbDec (.instr(instr), .regWrite(regWrite), .dstSel(dstSel), .wbSel(wbSel));

	branchUnit branch (
		.instr(instr), .cmpEq(cmpEq), .cmpSign(cmpSign),
		.isBranch(isBranch), .npcOp(npcOp), .nullifySlot(nullifySlot)
	);

	exceptionDetect excDet (
		.clk(clk), .rst(rst), .instr(instr),
		.regWrite(regWrite), .memWrite(memWrite), .isBranch(isBranch),
		.prevBranch(exIsBranch), // Branch now in execute makes this one its slot
		.flush(flush), .fetchExc(fetchExc), .fetchExcCode(fetchExcCode),
		.exception(exception), .excCode(excCode), .inDelaySlot(inDelaySlot)
	);

	// --------------------
	// Decode-to-execute registers
	assign idCtrl = '{aluOp: aluOp, shiftByShamt: shiftByShamt, extOp: extOp,
		regWrite: regWrite, dstSel: dstSel, wbSel: wbSel, memRead: memRead,
		memWrite: memWrite, memSize: memSize, isBranch: isBranch};
	assign idExc = '{exception: exception, excCode: excCode, inDelaySlot: inDelaySlot};

	pipeReg #(.payload_t(ctrlWord_t)) ctrlReg (
		.clk(clk), .rst(rst), .inValid(instrValid), .stall(stall), .flush(flush),
		.inData(idCtrl), .outValid(exValid), .outData(exCtrl)
	);

	pipeReg #(.payload_t(excInfo_t)) excReg ( // Its valid copy matches exValid
		.clk(clk), .rst(rst), .inValid(instrValid), .stall(stall), .flush(flush),
		.inData(idExc), .outValid(), .outData(exExc)
	);

	assign exAluOp = exCtrl.aluOp;
	assign exShiftByShamt = exCtrl.shiftByShamt;
	assign exExtOp = exCtrl.extOp;
	assign exRegWrite = exCtrl.regWrite;
	assign exDstSel = exCtrl.dstSel;
	assign exWbSel = exCtrl.wbSel;
	assign exMemRead = exCtrl.memRead;
	assign exMemWrite = exCtrl.memWrite;
	assign exMemSize = exCtrl.memSize;
	assign exIsBranch = exCtrl.isBranch;
	assign exException = exExc.exception;
	assign exExcCode = exExc.excCode;
	assign exInDelaySlot = exExc.inDelaySlot;

endmodule

/* rtl/pipeReg.sv */
module pipeReg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     inValid,
	input  logic     stall,
	input  logic     flush,
	input  payload_t inData,
	output logic     outValid,
	output payload_t outData
);

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			outValid <= 1'b0;
			outData <= '0; // Controls read as inactive after a bubble
		end
		else if (!stall) begin
			outValid <= inValid;
			outData <= inData;
		end
	end

	// A flush must beat a stall in the same cycle
	assert property (@(posedge clk) disable iff (!rst) flush |=> !outValid)
		else $error("stage still valid after flush");

endmodule

/* rtl/exceptionDetect.sv */
module exceptionDetect (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [isaPkg::instrWidth-1:0] instr,
	input  logic                          regWrite,
	input  logic                          memWrite,
	input  logic                          isBranch,
	input  logic                          prevBranch,
	input  logic                          flush,
	input  logic                          fetchExc,
	input  ctrlPkg::excCode_t             fetchExcCode,
	output logic                          exception,
	output ctrlPkg::excCode_t             excCode,
	output logic                          inDelaySlot
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic                  resetHold;
	logic                  isBreak;
	logic                  isSyscall;
	logic                  known;

	assign isBreak = (instr[instrWidth-1 -: opWidth] == opSpecial)
		&& (instr[functWidth-1:0] == fnBreak);
	assign isSyscall = (instr[instrWidth-1 -: opWidth] == opSpecial)
		&& (instr[functWidth-1:0] == fnSyscall);

	// Anything that changes state is a recognized instruction
	assign known = regWrite || memWrite || isBranch || isBreak || isSyscall;

	always_ff @(posedge clk) begin
		if (!rst)
			resetHold <= 1'b1; // Decode holds garbage in the first cycle out of reset
		else
			resetHold <= 1'b0;
	end

	// --------------------
	// Priority: fetch, reserved, break, syscall
	always_comb begin
		exception = 1'b1;
		excCode = excNone;
		if (fetchExc)
			excCode = fetchExcCode;
		else if (!known && !resetHold && !flush)
			excCode = excRi;
		else if (isBreak)
			excCode = excBp;
		else if (isSyscall)
			excCode = excSys;
		else
			exception = 1'b0;
	end

	assign inDelaySlot = prevBranch; // The previous instruction was a branch or jump

	// Fetch must never hand over an exception with an empty code
	assert property (@(posedge clk) disable iff (!rst) exception == (excCode != excNone))
		else $error("exception flag and code disagree");

endmodule

/* rtl/branchUnit.sv */
module branchUnit (
	input  logic [isaPkg::instrWidth-1:0] instr,
	input  logic                          cmpEq,
	input  ctrlPkg::cmpSign_t             cmpSign,
	output logic                          isBranch,
	output ctrlPkg::npcOp_t               npcOp,
	output logic                          nullifySlot
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [opWidth-1:0]    op;
	logic [functWidth-1:0] funct;
	logic [regWidth-1:0]   rt;
	logic                  taken;
	logic                  likely;

	assign op = instr[instrWidth-1 -: opWidth];
	assign funct = instr[functWidth-1:0];
	assign rt = instr[16 +: regWidth];

	// --------------------
	// Condition of each conditional branch
	always_comb begin
		isBranch = 1'b0;
		taken = 1'b0; // Only conditional branches set this
		likely = 1'b0;
		npcOp = npcSeq;
		case (op)
			opBeq, opBeql: begin
				isBranch = 1'b1;
				taken = cmpEq;
				likely = (op == opBeql);
			end
			opBne, opBnel: begin
				isBranch = 1'b1;
				taken = !cmpEq;
				likely = (op == opBnel);
			end
			opBlez, opBlezl: begin
				isBranch = 1'b1;
				taken = (cmpSign != cmpPos);
				likely = (op == opBlezl);
			end
			opBgtz, opBgtzl: begin
				isBranch = 1'b1;
				taken = (cmpSign == cmpPos);
				likely = (op == opBgtzl);
			end
			opRegimm: begin
				case (rt)
					rtBltz, rtBltzl, rtBltzal: begin
						isBranch = 1'b1;
						taken = (cmpSign == cmpNeg);
					end
					rtBgez, rtBgezl, rtBgezal: begin
						isBranch = 1'b1;
						taken = (cmpSign != cmpNeg);
					end
					default: isBranch = 1'b0;
				endcase
				likely = (rt == rtBltzl || rt == rtBgezl);
			end
			opJ, opJal: begin
				isBranch = 1'b1;
				npcOp = npcJump;
			end
			opSpecial: begin
				if (funct == fnJr || funct == fnJalr) begin
					isBranch = 1'b1;
					npcOp = npcReg;
				end
			end
			default: isBranch = 1'b0;
		endcase
		if (taken)
			npcOp = npcBranch;
	end

	assign nullifySlot = likely && !taken; // Skip the slot of a likely branch that falls through

	// No clock reaches this block, so the check is a deferred one
	always_comb begin
		assert final (!nullifySlot || isBranch)
			else $error("nullifySlot raised for a non-branch instruction");
	end

endmodule

/* rtl/writebackDecoder.sv */
module writebackDecoder (
	input  logic [isaPkg::instrWidth-1:0] instr,
	output logic                          regWrite,
	output ctrlPkg::dstSel_t              dstSel,
	output ctrlPkg::wbSel_t               wbSel
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [opWidth-1:0]    op;
	logic [functWidth-1:0] funct;
	logic [regWidth-1:0]   rt;

	assign op = instr[instrWidth-1 -: opWidth];
	assign funct = instr[functWidth-1:0];
	assign rt = instr[16 +: regWidth];

	always_comb begin
		regWrite = 1'b0;
		dstSel = dstRt;
		wbSel = wbAlu;
		case (op)
			opSpecial: begin
				dstSel = dstRd;
				case (funct)
					fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
					fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav:
						regWrite = 1'b1;
					fnJalr: begin
						regWrite = 1'b1;
						wbSel = wbLink;
					end
					default: regWrite = 1'b0; // jr, break, syscall and dropped functs write nothing
				endcase
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori: regWrite = 1'b1;
			opLui: begin
				regWrite = 1'b1;
				wbSel = wbImm;
			end
			opLb, opLh, opLw, opLbu, opLhu: begin
				regWrite = 1'b1;
				wbSel = wbMem;
			end
			opJal: begin
				regWrite = 1'b1;
				dstSel = dstLink;
				wbSel = wbLink;
			end
			opRegimm: begin
				if (rt == rtBltzal || rt == rtBgezal) begin // Link even when not taken
					regWrite = 1'b1;
					dstSel = dstLink;
					wbSel = wbLink;
				end
			end
			default: regWrite = 1'b0;
		endcase
	end

endmodule

/* rtl/memDecoder.sv */
module memDecoder (
	input  logic [isaPkg::instrWidth-1:0] instr,
	output logic                          memRead,
	output logic                          memWrite,
	output ctrlPkg::memSize_t             memSize
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [opWidth-1:0] op;

	assign op = instr[instrWidth-1 -: opWidth];

	always_comb begin
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = memWord;
		case (op)
			opLb: begin
				memRead = 1'b1;
				memSize = memByte;
			end
			opLbu: begin
				memRead = 1'b1;
				memSize = memByteU;
			end
			opLh: begin
				memRead = 1'b1;
				memSize = memHalf;
			end
			opLhu: begin
				memRead = 1'b1;
				memSize = memHalfU;
			end
			opLw: memRead = 1'b1;
			opSb: begin
				memWrite = 1'b1;
				memSize = memByte; // Stores never extend so the signed codes serve
			end
			opSh: begin
				memWrite = 1'b1;
				memSize = memHalf;
			end
			opSw: memWrite = 1'b1;
			default: memSize = memWord;
		endcase
	end

endmodule

/* rtl/aluDecoder.sv */
module aluDecoder (
	input  logic [isaPkg::instrWidth-1:0] instr,
	output ctrlPkg::aluOp_t               aluOp,
	output logic                          shiftByShamt,
	output ctrlPkg::extOp_t               extOp
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [opWidth-1:0]    op;
	logic [functWidth-1:0] funct;

	assign op = instr[instrWidth-1 -: opWidth];
	assign funct = instr[functWidth-1:0];

	always_comb begin
		aluOp = aluNone; // Branches, jumps and lui leave the ALU idle
		shiftByShamt = 1'b0;
		extOp = extZero;
		case (op)
			opSpecial: begin
				case (funct)
					fnAdd:  aluOp = aluAdd;
					fnAddu: aluOp = aluAddu;
					fnSub:  aluOp = aluSub;
					fnSubu: aluOp = aluSubu;
					fnAnd:  aluOp = aluAnd;
					fnOr:   aluOp = aluOr;
					fnXor:  aluOp = aluXor;
					fnNor:  aluOp = aluNor;
					fnSlt:  aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnSllv: aluOp = aluSll;
					fnSrlv: aluOp = aluSrl;
					fnSrav: aluOp = aluSra;
					fnSll: begin
						aluOp = aluSll;
						shiftByShamt = 1'b1; // Constant shifts take the amount from shamt
					end
					fnSrl: begin
						aluOp = aluSrl;
						shiftByShamt = 1'b1;
					end
					fnSra: begin
						aluOp = aluSra;
						shiftByShamt = 1'b1;
					end
					default: aluOp = aluNone;
				endcase
			end
			opAddi: begin
				aluOp = aluAdd;
				extOp = extSign;
			end
			opAddiu: begin
				aluOp = aluAddu;
				extOp = extSign;
			end
			opSlti: begin
				aluOp = aluSlt;
				extOp = extSign;
			end
			opSltiu: begin
				aluOp = aluSltu;
				extOp = extSign; // Sign extended, then compared unsigned
			end
			opAndi: aluOp = aluAnd;
			opOri:  aluOp = aluOr;
			opXori: aluOp = aluXor;
			opLui:  extOp = extLui;
			// Address is base plus sign extended offset
			opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw: begin
				aluOp = aluAdd;
				extOp = extSign;
			end
			default: aluOp = aluNone;
		endcase
	end

endmodule

/* rtl/ctrlPkg.sv */
package ctrlPkg;

	// --------------------
	// Execute-stage selects
	typedef enum logic [3:0] {
		aluAdd, aluAddu, aluSub, aluSubu,
		aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu,
		aluSll, aluSrl, aluSra,
		aluNone
	} aluOp_t;

	typedef enum logic [1:0] {
		extZero = 2'b00,
		extSign = 2'b01,
		extLui  = 2'b10 // Immediate goes to the upper half
	} extOp_t;

	typedef enum logic [1:0] {
		npcSeq    = 2'b00,
		npcBranch = 2'b01,
		npcJump   = 2'b10,
		npcReg    = 2'b11
	} npcOp_t;

	typedef enum logic [1:0] {
		wbAlu  = 2'b00,
		wbImm  = 2'b01,
		wbLink = 2'b10, // Return address
		wbMem  = 2'b11
	} wbSel_t;

	typedef enum logic [1:0] {
		dstRt   = 2'b00,
		dstRd   = 2'b01,
		dstLink = 2'b10
	} dstSel_t;

	// Five access kinds need a third bit
	typedef enum logic [2:0] {
		memByte, memByteU, memHalf, memHalfU, memWord
	} memSize_t;

	// Result of comparing rs against zero in register read
	typedef enum logic [1:0] {
		cmpZero = 2'b00,
		cmpPos  = 2'b01,
		cmpNeg  = 2'b10
	} cmpSign_t;

	// --------------------
	// Exception codes, as in the Cause register
	typedef logic [4:0] excCode_t;

	localparam excCode_t excNone = 5'd0;
	localparam excCode_t excSys  = 5'd8;
	localparam excCode_t excBp   = 5'd9;
	localparam excCode_t excRi   = 5'd10;

	// --------------------
	// Payloads of the decode-to-execute register
	typedef struct packed {
		aluOp_t   aluOp;
		logic     shiftByShamt;
		extOp_t   extOp;
		logic     regWrite;
		dstSel_t  dstSel;
		wbSel_t   wbSel;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
		logic     isBranch;
	} ctrlWord_t;

	typedef struct packed {
		logic     exception;
		excCode_t excCode;
		logic     inDelaySlot;
	} excInfo_t;

endpackage

/* rtl/isaPkg.sv */
package isaPkg;

	// --------------------
	// Instruction word fields
	localparam int instrWidth = 32;
	localparam int opWidth = 6;
	localparam int functWidth = 6;
	localparam int regWidth = 5;

	localparam logic [regWidth-1:0] linkReg = 5'd31; // Written by jal and the linking branches

	// --------------------
	// Primary opcodes that the decoder keeps
	typedef enum logic [opWidth-1:0] {
		opSpecial = 6'b000000,
		opRegimm  = 6'b000001,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opBlez    = 6'b000110,
		opBgtz    = 6'b000111,
		opAddi    = 6'b001000,
		opAddiu   = 6'b001001,
		opSlti    = 6'b001010,
		opSltiu   = 6'b001011,
		opAndi    = 6'b001100,
		opOri     = 6'b001101,
		opXori    = 6'b001110,
		opLui     = 6'b001111,
		opBeql    = 6'b010100, // Likely forms nullify the slot when not taken
		opBnel    = 6'b010101,
		opBlezl   = 6'b010110,
		opBgtzl   = 6'b010111,
		opLb      = 6'b100000,
		opLh      = 6'b100001,
		opLw      = 6'b100011,
		opLbu     = 6'b100100,
		opLhu     = 6'b100101,
		opSb      = 6'b101000,
		opSh      = 6'b101001,
		opSw      = 6'b101011
	} opcode_t;

	// SPECIAL function codes
	typedef enum logic [functWidth-1:0] {
		fnSll  = 6'b000000, fnSrl  = 6'b000010, fnSra     = 6'b000011,
		fnSllv = 6'b000100, fnSrlv = 6'b000110, fnSrav    = 6'b000111,
		fnJr   = 6'b001000, fnJalr = 6'b001001, fnSyscall = 6'b001100,
		fnBreak = 6'b001101,
		fnAdd  = 6'b100000, fnAddu = 6'b100001, fnSub     = 6'b100010,
		fnSubu = 6'b100011, fnAnd  = 6'b100100, fnOr      = 6'b100101,
		fnXor  = 6'b100110, fnNor  = 6'b100111, fnSlt     = 6'b101010,
		fnSltu = 6'b101011
	} funct_t;

	// REGIMM branches, selected by the rt field
	typedef enum logic [regWidth-1:0] {
		rtBltz   = 5'b00000,
		rtBgez   = 5'b00001,
		rtBltzl  = 5'b00010,
		rtBgezl  = 5'b00011,
		rtBltzal = 5'b10000,
		rtBgezal = 5'b10001
	} regimm_t;

endpackage
